// ==== Makefile ====
BIN := obj_dir/Vsdmac_regs_tb

.PHONY: run clean

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "all tests passed"

$(BIN): $(shell cat sdmac_regs.f) sdmac_regs.f
	verilator --binary --timing --assert --top-module sdmac_regs_tb -f sdmac_regs.f

clean:
	rm -rf obj_dir

// ==== sdmac_apb_decode.sv ====
`timescale 1ns/1ps

module sdmac_apb_decode (
  input  logic                                  CLK,
  input  logic                                  RST_,
  input  logic                                  psel,
  input  logic                                  penable,
  input  logic                                  pwrite,
  input  logic [sdmac_regmap_pkg::addr_w-1:0]   paddr,
  input  logic [sdmac_regmap_pkg::data_w-1:0]   pwdata,
  output logic [sdmac_regmap_pkg::data_w-1:0]   prdata,
  output logic                                  pready,
  output logic                                  pslverr,
  sdmac_reg_if.ctrl                             regs
);

  logic access;   // APB access phase
  logic rd_ok;    // Offset readable
  logic wr_ok;    // Offset writable
  logic err;      // Access to be refused
  logic wr_en;    // Good write in its access cycle
  logic rd_wait;  // FSM: 0 idle, 1 read wait state done

  logic [sdmac_regmap_pkg::data_w-1:0] rd_mux;  // Read-back before register

  assign access = psel & penable;

  // Offset decode
  always_comb begin
    rd_ok = 1'b0;
    wr_ok = 1'b0;
    case (paddr)
      sdmac_regmap_pkg::cntr_off: begin
        rd_ok = 1'b1;
        wr_ok = 1'b1;
      end
      sdmac_regmap_pkg::istr_off: rd_ok = 1'b1;  // Status is read only
      sdmac_regmap_pkg::st_dma_off,
      sdmac_regmap_pkg::flush_off,
      sdmac_regmap_pkg::clr_int_off,
      sdmac_regmap_pkg::sp_dma_off,
      sdmac_regmap_pkg::acr_off: wr_ok = 1'b1;
      default: ;  // Unmapped, both stay low
    endcase
  end

  assign err   = pwrite ? ~wr_ok : ~rd_ok;
  assign wr_en = access & pwrite & ~err;

  // Strobes, taken on the edge ending the access phase
  assign regs.cntr_wr   = wr_en & (paddr == sdmac_regmap_pkg::cntr_off);
  assign regs.st_dma    = wr_en & (paddr == sdmac_regmap_pkg::st_dma_off);
  assign regs.flush_req = wr_en & (paddr == sdmac_regmap_pkg::flush_off);
  assign regs.clr_int   = wr_en & (paddr == sdmac_regmap_pkg::clr_int_off);
  assign regs.sp_dma    = wr_en & (paddr == sdmac_regmap_pkg::sp_dma_off);
  assign regs.acr_wr    = wr_en & (paddr == sdmac_regmap_pkg::acr_off);
  assign regs.wdata     = pwdata;  // Receivers pick the view

  // Zero-extended read mux
  always_comb begin
    rd_mux = '0;
    if (paddr == sdmac_regmap_pkg::cntr_off)
      rd_mux[$bits(sdmac_fields_pkg::cntr_t)-1:0] = regs.cntr_q;
    else if (paddr == sdmac_regmap_pkg::istr_off)
      rd_mux[$bits(sdmac_fields_pkg::istr_t)-1:0] = regs.istr_q;
  end

  // Read wait state and registered read data
  always_ff @(posedge CLK or negedge RST_) begin
    if (!RST_) begin
      rd_wait <= 1'b0;
      prdata  <= '0;
    end else if (rd_wait) begin
      rd_wait <= 1'b0;  // Read completes this edge
    end else if (access && !pwrite) begin
      rd_wait <= 1'b1;
      prdata  <= rd_mux;  // Errored read returns zero
    end
  end

  // Writes finish at once, reads after the wait state
  assign pready  = (access & pwrite) | rd_wait;
  assign pslverr = pready & err;  // Master holds paddr until pready

endmodule

// ==== sdmac_cntr.sv ====
`timescale 1ns/1ps

module sdmac_cntr (
  input  logic          CLK,
  input  logic          RST_,
  sdmac_reg_if.cntr_side regs,
  output logic          dma_dir,
  output logic          preset
);

  // Control register load from the control view of the write word
  always_ff @(posedge CLK or negedge RST_) begin
    if (!RST_)
      regs.cntr_q <= '0;
    else if (regs.cntr_wr)
      regs.cntr_q <= regs.wdata.cntr_v.cntr;  // All 9 bits kept
  end

  // DMA enable flag
  always_ff @(posedge CLK or negedge RST_) begin
    if (!RST_) begin
      regs.dma_ena <= 1'b0;
    end else begin
      if (regs.sp_dma)
        regs.dma_ena <= 1'b0;  // Stop wins
      else if (regs.st_dma)
        regs.dma_ena <= 1'b1;
    end
  end

  // Field outputs
  assign dma_dir = regs.cntr_q.dma_dir;  // Transfer direction
  assign preset  = regs.cntr_q.preset;   // Peripheral reset to SCSI core

endmodule

// ==== sdmac_fields_pkg.sv ====
package sdmac_fields_pkg;

  // Control register, 9 bits stored
  typedef struct packed {
    logic [3:0] rsvd_hi;  // Bits 8:5, kept for read-back
    logic       preset;   // Bit 4, peripheral reset
    logic       rsvd3;    // Bit 3
    logic       int_ena;  // Bit 2, interrupt enable
    logic       dma_dir;  // Bit 1, DMA direction
    logic       rsvd0;    // Bit 0
  } cntr_t;

  // Interrupt status word as read by the CPU
  typedef struct packed {
    logic [3:0] zero_hi;     // Bits 8:5 read as zero
    logic       dma_ena;     // Bit 4
    logic       int_act;     // Bit 3, pending and enabled
    logic       int_pend;    // Bit 2, latched peripheral interrupt
    logic       fifo_full;   // Bit 1
    logic       fifo_empty;  // Bit 0
  } istr_t;

  // Write word seen as control data
  typedef struct packed {
    logic [22:0] rsvd;  // Ignored
    cntr_t       cntr;  // Low 9 bits
  } cntr_wr_t;

  // Write word seen as ACR load
  typedef struct packed {
    logic [5:0]  rsvd;  // Bits 31:26
    logic        a1;    // Bit 25, A1 address bit
    logic [24:0] addr;  // Start address, FIFO side only
  } acr_wr_t;

  // One APB write word, view picked by the decoded offset
  typedef union packed {
    cntr_wr_t cntr_v;
    acr_wr_t  acr_v;
  } wdata_u;

endpackage

// ==== sdmac_fifo_ctrl.sv ====
`timescale 1ns/1ps

module sdmac_fifo_ctrl (
  input  logic           CLK,
  input  logic           RST_,
  sdmac_reg_if.fifo_side regs,
  input  logic           stop_flush,
  output logic           flush_fifo,
  output logic           acr_wr,
  output logic           a1
);

  // Flush request, held until the FIFO side acknowledges
  always_ff @(posedge CLK or negedge RST_) begin
    if (!RST_) begin
      flush_fifo <= 1'b1;  // FIFO starts flushed
    end else begin
      if (regs.flush_req)
        flush_fifo <= 1'b1;
      if (stop_flush)
        flush_fifo <= 1'b0;  // Stop wins
    end
  end

  // A1 from the ACR view of the write word
  always_ff @(posedge CLK or negedge RST_) begin
    if (!RST_)
      a1 <= 1'b0;
    else if (regs.acr_wr)
      a1 <= regs.wdata.acr_v.a1;
  end

  assign acr_wr = regs.acr_wr;  // Load pulse to FIFO byte pointer

endmodule

// ==== sdmac_istr.sv ====
`timescale 1ns/1ps

module sdmac_istr (
  input  logic           CLK,
  input  logic           RST_,
  sdmac_reg_if.istr_side regs,
  input  logic           fifo_empty,
  input  logic           fifo_full,
  input  logic           inta_i,
  output logic           irq_n
);

  logic int_pend;  // Latched peripheral interrupt
  logic int_act;   // Pending and enabled

  // Interrupt latch
  always_ff @(posedge CLK or negedge RST_) begin
    if (!RST_) begin
      int_pend <= 1'b0;
    end else begin
      if (inta_i)
        int_pend <= 1'b1;  // Set wins over clear
      else if (regs.clr_int)
        int_pend <= 1'b0;
    end
  end

  assign int_act = int_pend & regs.cntr_q.int_ena;

  // Status word for read-back
  always_comb begin
    regs.istr_q            = '0;  // Upper bits read zero
    regs.istr_q.fifo_empty = fifo_empty;
    regs.istr_q.fifo_full  = fifo_full;
    regs.istr_q.int_pend   = int_pend;
    regs.istr_q.int_act    = int_act;
    regs.istr_q.dma_ena    = regs.dma_ena;  // From control side
  end

  // Active-low interrupt to the CPU
  assign irq_n = ~int_act;

endmodule

// ==== sdmac_reg_if.sv ====
`timescale 1ns/1ps

interface sdmac_reg_if;

  // Action strobes, one access cycle wide
  logic cntr_wr;    // Control register load
  logic st_dma;     // Start DMA
  logic sp_dma;     // Stop DMA
  logic clr_int;    // Clear interrupt latch
  logic flush_req;  // Flush FIFO request
  logic acr_wr;     // ACR load

  sdmac_fields_pkg::wdata_u wdata;  // APB write word, both views

  // Register state back to the decoder
  sdmac_fields_pkg::cntr_t cntr_q;
  sdmac_fields_pkg::istr_t istr_q;
  logic                    dma_ena;

  modport ctrl (
    output cntr_wr, st_dma, sp_dma, clr_int, flush_req, acr_wr, wdata,
    input  cntr_q, istr_q
  );
  modport cntr_side (input cntr_wr, st_dma, sp_dma, wdata, output cntr_q, dma_ena);
  modport istr_side (input clr_int, cntr_q, dma_ena, output istr_q);
  modport fifo_side (input flush_req, acr_wr, wdata);

endinterface

// ==== sdmac_regmap_pkg.sv ====
package sdmac_regmap_pkg;

  // APB bus widths
  localparam int addr_w = 8;   // Byte offset into register window
  localparam int data_w = 32;  // APB data bus

  // Read/write register
  localparam logic [addr_w-1:0] cntr_off    = 8'h0C;  // Control register

  // Read only
  localparam logic [addr_w-1:0] istr_off    = 8'h10;  // Interrupt status

  // Write-only action offsets, data ignored except ACR
  localparam logic [addr_w-1:0] st_dma_off  = 8'h14;  // Start DMA
  localparam logic [addr_w-1:0] flush_off   = 8'h18;  // Flush FIFO
  localparam logic [addr_w-1:0] clr_int_off = 8'h1C;  // Clear interrupt
  localparam logic [addr_w-1:0] sp_dma_off  = 8'h20;  // Stop DMA
  localparam logic [addr_w-1:0] acr_off     = 8'h24;  // Address control, loads byte ptr

endpackage

// ==== sdmac_regs.f ====
sdmac_regmap_pkg.sv
sdmac_fields_pkg.sv
sdmac_reg_if.sv
sdmac_apb_decode.sv
sdmac_cntr.sv
sdmac_istr.sv
sdmac_fifo_ctrl.sv
sdmac_regs.sv
sdmac_regs_tb.sv

// ==== sdmac_regs.sv ====
`timescale 1ns/1ps

module sdmac_regs (
  input  logic                                CLK,
  input  logic                                RST_,
  // APB slave
  input  logic                                psel,
  input  logic                                penable,
  input  logic                                pwrite,
  input  logic [sdmac_regmap_pkg::addr_w-1:0] paddr,
  input  logic [sdmac_regmap_pkg::data_w-1:0] pwdata,
  output logic [sdmac_regmap_pkg::data_w-1:0] prdata,
  output logic                                pready,
  output logic                                pslverr,
  // FIFO and SCSI core side
  input  logic                                fifo_empty,
  input  logic                                fifo_full,
  input  logic                                inta_i,
  input  logic                                stop_flush,
  output logic                                irq_n,
  output logic                                dma_dir,
  output logic                                preset,
  output logic                                dma_ena,
  output logic                                flush_fifo,
  output logic                                acr_wr,
  output logic                                a1
);

  sdmac_reg_if regs_if ();  // Decoder to register modules

  sdmac_apb_decode u_apb_decode (
    .CLK     (CLK),
    .RST_    (RST_),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .regs    (regs_if.ctrl)
  );

  sdmac_cntr u_cntr (
    .CLK     (CLK),
    .RST_    (RST_),
    .regs    (regs_if.cntr_side),
    .dma_dir (dma_dir),
    .preset  (preset)
  );

  sdmac_istr u_istr (
    .CLK        (CLK),
    .RST_       (RST_),
    .regs       (regs_if.istr_side),
    .fifo_empty (fifo_empty),
    .fifo_full  (fifo_full),
    .inta_i     (inta_i),
    .irq_n      (irq_n)
  );

  sdmac_fifo_ctrl u_fifo_ctrl (
    .CLK        (CLK),
    .RST_       (RST_),
    .regs       (regs_if.fifo_side),
    .stop_flush (stop_flush),
    .flush_fifo (flush_fifo),
    .acr_wr     (acr_wr),
    .a1         (a1)
  );

  assign dma_ena = regs_if.dma_ena;  // DMA enable flag out to the engine

endmodule

// ==== sdmac_regs_tb.sv ====
`timescale 1ns/1ps

module sdmac_regs_tb;

  logic        CLK;
  logic        RST_;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [7:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic        fifo_empty;
  logic        fifo_full;
  logic        inta_i;
  logic        stop_flush;
  logic        irq_n;
  logic        dma_dir;
  logic        preset;
  logic        dma_ena;
  logic        flush_fifo;
  logic        acr_wr;
  logic        a1;

  integer      seed;
  integer      errors;
  integer      tests;
  integer      errors_at_start;
  integer      acr_pulses;       // ACR load pulses seen at clock edges
  integer      pulses_before;
  logic [31:0] data;
  logic [31:0] rd;
  logic        err;
  logic        a1_exp;

  sdmac_regs dut_i (.CLK(CLK), .RST_(RST_), .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .fifo_empty(fifo_empty), .fifo_full(fifo_full), .inta_i(inta_i),
    .stop_flush(stop_flush), .irq_n(irq_n), .dma_dir(dma_dir), .preset(preset),
    .dma_ena(dma_ena), .flush_fifo(flush_fifo), .acr_wr(acr_wr), .a1(a1));

  always #20 CLK = ~CLK;  // 40 ns period

  always @(posedge CLK) begin
    if (acr_wr)
      acr_pulses++;
  end

  // Writes complete in their first access cycle, reads do not
  assert property (@(posedge CLK) disable iff (!RST_)
      (psel && $rose(penable)) |-> (pready == pwrite))
    else begin
      $display("FAIL %0t: pready wrong in first access cycle", $time);
      errors++;
    end

  // Read wait state lasts exactly one cycle
  assert property (@(posedge CLK) disable iff (!RST_)
      (psel && penable && !pwrite && !pready) |=> pready)
    else begin
      $display("FAIL %0t: read not completed after one wait state", $time);
      errors++;
    end

  // ACR strobe only in the access cycle of a write to acr_off
  assert property (@(posedge CLK) disable iff (!RST_)
      acr_wr |-> (psel && penable && pwrite && paddr == sdmac_regmap_pkg::acr_off))
    else begin
      $display("FAIL %0t: acr_wr outside an ACR write access", $time);
      errors++;
    end

  task automatic check(input logic ok, input string what);
    assert (ok)
      else begin
        $display("FAIL %0t: %0s", $time, what);
        errors++;
      end
  endtask

  task automatic finish_test(input string name);
    tests++;
    if (errors == errors_at_start)
      $display("test %0s: ok", name);
    else
      $display("test %0s: %0d errors", name, errors - errors_at_start);
    errors_at_start = errors;
  endtask

  task automatic report_timeout(input logic [7:0] addr);
    $display("timeout: no pready within 10 cycles at offset %h", addr);
    errors++;
  endtask

  task automatic next_cycle;
    @(posedge CLK);
    #2;  // Drive point after the edge
  endtask

  // Expected status word from the documented bit positions
  function automatic logic [31:0] status_word(input logic empty, input logic full,
                                              input logic pend, input logic ena,
                                              input logic dma);
    logic [31:0] w;
    w    = '0;
    w[0] = empty;
    w[1] = full;
    w[2] = pend;
    w[3] = pend & ena;  // Active only when enabled
    w[4] = dma;
    return w;
  endfunction

  task automatic apb_transfer(input logic write, input logic [7:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic slverr);
    integer waited;
    psel    = 1'b1;  // Setup phase
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = wdata;
    next_cycle();
    penable = 1'b1;  // Access phase
    #1;
    waited = 0;
    while (!pready && waited < 10) begin
      @(posedge CLK);
      #3;
      waited++;
    end
    if (!pready)
      report_timeout(addr);
    rdata  = prdata;
    slverr = pslverr;
    next_cycle();  // Completing edge
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] wdata,
                           output logic slverr);
    logic [31:0] ignored;
    apb_transfer(1'b1, addr, wdata, ignored, slverr);
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] rdata,
                          output logic slverr);
    apb_transfer(1'b0, addr, 32'h0, rdata, slverr);
  endtask

  task automatic pulse_inta;
    inta_i = 1'b1;
    next_cycle();
    inta_i = 1'b0;
  endtask

  task automatic pulse_stop_flush;
    stop_flush = 1'b1;
    next_cycle();
    stop_flush = 1'b0;
  endtask

  initial begin
    seed            = 86412;
    errors          = 0;
    tests           = 0;
    errors_at_start = 0;
    acr_pulses      = 0;
    CLK             = 1'b0;
    RST_            = 1'b0;
    psel            = 1'b0;
    penable         = 1'b0;
    pwrite          = 1'b0;
    paddr           = '0;
    pwdata          = '0;
    fifo_empty      = 1'b1;
    fifo_full       = 1'b0;
    inta_i          = 1'b0;
    stop_flush      = 1'b0;
    repeat (2) @(posedge CLK);
    #2;
    RST_ = 1'b1;

    check({flush_fifo, irq_n, pready, pslverr, acr_wr, dma_ena, dma_dir, preset, a1}
          === 9'b110000000, "outputs after reset");
    check(prdata === 32'h0, "prdata after reset");
    finish_test("reset_values");

    repeat (4) begin
      data = $random(seed);
      apb_write(sdmac_regmap_pkg::cntr_off, data, err);
      check(err === 1'b0, "pslverr on control write");
      check(dma_dir === data[1], "dma_dir follows bit 1");
      check(preset === data[4], "preset follows bit 4");
      apb_read(sdmac_regmap_pkg::cntr_off, rd, err);
      check(rd === {23'b0, data[8:0]}, "control read-back");
    end
    finish_test("control_reg");

    fifo_empty = 1'b0;  // Different flags for status reads
    fifo_full  = 1'b1;
    apb_write(sdmac_regmap_pkg::st_dma_off, $random(seed), err);
    check(dma_ena === 1'b1, "dma_ena after start");
    apb_read(sdmac_regmap_pkg::istr_off, rd, err);
    check(rd === status_word(1'b0, 1'b1, 1'b0, 1'b0, 1'b1), "status with DMA on");
    apb_write(sdmac_regmap_pkg::sp_dma_off, $random(seed), err);
    check(dma_ena === 1'b0, "dma_ena after stop");
    fifo_empty = 1'b1;  // Flags swapped for the rest of the run
    fifo_full  = 1'b0;
    apb_read(sdmac_regmap_pkg::istr_off, rd, err);
    check(rd === status_word(1'b1, 1'b0, 1'b0, 1'b0, 1'b0), "status with DMA off");
    finish_test("dma_enable");

    apb_write(sdmac_regmap_pkg::cntr_off, 32'h0000_0004, err);  // int_ena only
    pulse_inta();
    check(irq_n === 1'b0, "irq_n low with int_ena set");
    apb_read(sdmac_regmap_pkg::istr_off, rd, err);
    check(rd === status_word(1'b1, 1'b0, 1'b1, 1'b1, 1'b0), "status with interrupt");
    apb_write(sdmac_regmap_pkg::clr_int_off, 32'h0, err);
    check(irq_n === 1'b1, "irq_n after clear");
    apb_write(sdmac_regmap_pkg::cntr_off, 32'h0, err);
    pulse_inta();
    check(irq_n === 1'b1, "irq_n high with int_ena clear");
    apb_read(sdmac_regmap_pkg::istr_off, rd, err);
    check(rd === status_word(1'b1, 1'b0, 1'b1, 1'b0, 1'b0), "status pending, disabled");
    apb_write(sdmac_regmap_pkg::clr_int_off, 32'h0, err);
    finish_test("interrupt");

    pulse_stop_flush();
    check(flush_fifo === 1'b0, "flush_fifo after stop_flush");
    apb_write(sdmac_regmap_pkg::flush_off, 32'h0, err);
    check(flush_fifo === 1'b1, "flush_fifo after flush write");
    stop_flush = 1'b1;  // Held across a whole flush write
    apb_write(sdmac_regmap_pkg::flush_off, 32'h0, err);
    stop_flush = 1'b0;
    check(flush_fifo === 1'b0, "flush_fifo when flush meets stop_flush");
    data = $random(seed);
    repeat (2) begin
      pulses_before = acr_pulses;
      a1_exp        = data[25];
      apb_write(sdmac_regmap_pkg::acr_off, data, err);
      check(err === 1'b0, "pslverr on ACR write");
      check(a1 === a1_exp, "a1 from bit 25");
      check(acr_pulses - pulses_before == 1, "one acr_wr pulse per write");
      data = ~data;  // Other a1 value next round
    end
    finish_test("fifo_ctrl");

    apb_write(sdmac_regmap_pkg::cntr_off, 32'h0000_0012, err);
    pulses_before = acr_pulses;
    apb_write(sdmac_regmap_pkg::istr_off, $random(seed), err);
    check(err === 1'b1, "pslverr on status write");
    apb_read(sdmac_regmap_pkg::st_dma_off, rd, err);
    check(err === 1'b1, "pslverr on write-only read");
    apb_write(8'h30, $random(seed), err);
    check(err === 1'b1, "pslverr on unmapped write");
    apb_read(8'h30, rd, err);
    check(err === 1'b1, "pslverr on unmapped read");
    apb_read(sdmac_regmap_pkg::cntr_off, rd, err);
    check(rd === 32'h0000_0012, "control unchanged by errors");
    apb_read(sdmac_regmap_pkg::istr_off, rd, err);
    check(rd === status_word(1'b1, 1'b0, 1'b0, 1'b0, 1'b0), "status unchanged");
    check({flush_fifo, a1, dma_ena, dma_dir, preset}
          === {1'b0, a1_exp, 1'b0, 1'b1, 1'b1}, "outputs unchanged");
    check(acr_pulses == pulses_before, "no ACR strobe on errors");
    finish_test("errors");

    $display("%0d tests run, %0d checks failed", tests, errors);
    if (errors == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule
